/* verilog/umi_flex_defs.svh */
`ifndef UMI_FLEX_DEFS_SVH
`define UMI_FLEX_DEFS_SVH

//######################################################################
// UMI bus widths
//######################################################################

`define UMI_CW   32   // Command
`define UMI_AW   64   // Source and destination address
`define UMI_IDW  256  // Wide input data
`define UMI_ODW  64   // Narrow output data

//######################################################################
// Elastic buffer
//######################################################################

// Beat entries as a power of two
`define UMI_FIFO_DEPTH 4

`endif

/* verilog/umi_pkg.sv */
`include "umi_flex_defs.svh"

package umi_pkg;

   //###################################################################
   // Raw bus vectors
   //###################################################################

   typedef logic [`UMI_CW-1:0]  umi_cmd_vec_t;
   typedef logic [`UMI_AW-1:0]  umi_addr_t;
   typedef logic [`UMI_IDW-1:0] umi_idata_t;  // Request side data
   typedef logic [`UMI_ODW-1:0] umi_odata_t;  // Beat side data

   //###################################################################
   // Command word
   //###################################################################

   // Fields listed from the top bit down
   typedef struct packed {
      logic [4:0] hostid;
      logic [1:0] user;
      logic       ex;
      logic       eof;
      logic       eom;     // End of message
      logic [1:0] prot;
      logic [3:0] qos;
      logic [7:0] len;     // Words minus one
      logic [2:0] size;    // Log2 of word bytes
      logic [4:0] opcode;
   } umi_cmd_t;

endpackage

/* verilog/umi_flex_pkg.sv */
package umi_flex_pkg;

   // Splitter sequencing
   typedef enum logic {
      SPLIT_IDLE,  // Next beat comes from the input
      SPLIT_BUSY   // Remainder of a request pending
   } split_state_t;

   // One narrow beat as stored in the FIFO
   typedef struct packed {
      umi_pkg::umi_cmd_t   cmd;
      umi_pkg::umi_addr_t  dstaddr;
      umi_pkg::umi_addr_t  srcaddr;
      umi_pkg::umi_odata_t data;
   } umi_beat_t;

endpackage

/* verilog/umi_flex_ctrl.sv */
`timescale 1ns/1ps

module umi_flex_ctrl
  (
   input  logic                       umi_in_clk,
   input  logic                       umi_in_nreset,
   input  logic                       bypass,
   input  logic                       umi_in_valid,
   input  logic                       umi_out_ready,
   input  logic                       more_beats,
   input  logic                       fifo_full,
   input  logic                       fifo_empty,
   output logic                       umi_in_ready,
   output logic                       beat_take,
   output logic                       fifo_push,
   output logic                       fifo_pop,
   output logic                       umi_out_valid,
   output umi_flex_pkg::split_state_t state
   );

   import umi_flex_pkg::*;

   logic busy;
   logic beat_avail;

   assign busy       = (state == SPLIT_BUSY);
   assign beat_avail = umi_in_valid | busy;  // Fresh request or remainder

   //###################################################################
   // Beat consumption
   //###################################################################

   // FIFO write, or an output transfer when the FIFO is skipped
   assign beat_take = bypass ? (beat_avail & umi_out_ready) :
                               (beat_avail & ~fifo_full);

   assign fifo_push = ~bypass & beat_avail & ~fifo_full;
   assign fifo_pop  = ~bypass & ~fifo_empty & umi_out_ready;

   //###################################################################
   // Handshakes
   //###################################################################

   assign umi_out_valid = bypass ? beat_avail : ~fifo_empty;

   // New request only once the remainder is drained
   assign umi_in_ready = ~busy & (bypass ? umi_out_ready : ~fifo_full);

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         state <= SPLIT_IDLE;
      end
      else if (beat_take)
      begin
         state <= more_beats ? SPLIT_BUSY : SPLIT_IDLE;
      end
   end

endmodule

/* verilog/umi_split_datapath.sv */
`timescale 1ns/1ps
`include "umi_flex_defs.svh"

module umi_split_datapath
  (
   input  logic                    umi_in_clk,
   input  logic                    umi_in_nreset,
   input  logic                    beat_take,
   input  logic                    busy,
   input  umi_pkg::umi_cmd_t       umi_in_cmd,
   input  umi_pkg::umi_addr_t      umi_in_dstaddr,
   input  umi_pkg::umi_addr_t      umi_in_srcaddr,
   input  umi_pkg::umi_idata_t     umi_in_data,
   output logic                    more_beats,
   output umi_flex_pkg::umi_beat_t beat
   );

   import umi_pkg::*;

   localparam int BEAT_BYTES = `UMI_ODW / 8;

   umi_cmd_t   rem_cmd;
   umi_addr_t  rem_dstaddr;
   umi_addr_t  rem_srcaddr;
   umi_idata_t rem_data;

   umi_cmd_t   cur_cmd;
   umi_addr_t  cur_dstaddr;
   umi_addr_t  cur_srcaddr;
   umi_idata_t cur_data;
   umi_cmd_t   rem_cmd_next;
   logic [3:0] words_per_beat;
   logic [8:0] len_plus_one;

   // Remainder takes over while a split is in progress
   assign cur_cmd     = busy ? rem_cmd     : umi_in_cmd;
   assign cur_dstaddr = busy ? rem_dstaddr : umi_in_dstaddr;
   assign cur_srcaddr = busy ? rem_srcaddr : umi_in_srcaddr;
   assign cur_data    = busy ? rem_data    : umi_in_data;

   //###################################################################
   // Beat sizing
   //###################################################################

   // Words wider than the output bus still go one per beat
   assign words_per_beat = (cur_cmd.size > 3'd3) ? 4'd1 : 4'(BEAT_BYTES >> cur_cmd.size);
   assign len_plus_one   = {1'b0, cur_cmd.len} + 9'd1;
   assign more_beats     = len_plus_one > {5'd0, words_per_beat};

   always_comb
   begin
      beat.cmd     = cur_cmd;
      beat.cmd.len = more_beats ? {4'd0, words_per_beat - 4'd1} : cur_cmd.len;
      beat.cmd.eom = cur_cmd.eom & ~more_beats;  // Last beat only
      beat.dstaddr = cur_dstaddr;
      beat.srcaddr = cur_srcaddr;
      beat.data    = cur_data[`UMI_ODW-1:0];
   end

   // Words left after this beat with eom kept for the tail
   always_comb
   begin
      rem_cmd_next     = cur_cmd;
      rem_cmd_next.len = cur_cmd.len - {4'd0, words_per_beat};
   end

   //###################################################################
   // Remainder registers
   //###################################################################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         rem_cmd <= '0;
      else if (beat_take)
         rem_cmd <= rem_cmd_next;
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (beat_take)
      begin
         rem_dstaddr <= cur_dstaddr + BEAT_BYTES;
         rem_srcaddr <= cur_srcaddr + BEAT_BYTES;
         rem_data    <= cur_data >> `UMI_ODW;  // Next slice to the bottom
      end
   end

endmodule

/* verilog/umi_beat_fifo.sv */
`timescale 1ns/1ps

module umi_beat_fifo
  #(parameter int DEPTH = 4)  // Power of two
  (
   input  logic                    umi_in_clk,
   input  logic                    umi_in_nreset,
   input  logic                    push,
   input  logic                    pop,
   input  umi_flex_pkg::umi_beat_t din,
   output umi_flex_pkg::umi_beat_t dout,
   output logic                    full,
   output logic                    empty
   );

   import umi_flex_pkg::*;

   localparam int PW = $clog2(DEPTH);

   umi_beat_t   mem [DEPTH];
   logic [PW:0] wr_ptr;  // Extra bit tells full from empty
   logic [PW:0] rd_ptr;
   logic        do_push;
   logic        do_pop;

   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[PW] != rd_ptr[PW]) &&
                  (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);

   assign dout = mem[rd_ptr[PW-1:0]];  // Head visible without a read

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Storage
   always_ff @(posedge umi_in_clk)
   begin
      if (do_push)
         mem[wr_ptr[PW-1:0]] <= din;
   end

endmodule

/* verilog/umi_fifo_flex.sv */
`timescale 1ns/1ps
`include "umi_flex_defs.svh"

module umi_fifo_flex
  (
   input  logic                umi_in_clk,
   input  logic                umi_in_nreset,
   input  logic                bypass,        // Skip the FIFO
   input  logic                umi_in_valid,
   input  umi_pkg::umi_cmd_t   umi_in_cmd,
   input  umi_pkg::umi_addr_t  umi_in_dstaddr,
   input  umi_pkg::umi_addr_t  umi_in_srcaddr,
   input  umi_pkg::umi_idata_t umi_in_data,
   output logic                umi_in_ready,
   output logic                umi_out_valid,
   output umi_pkg::umi_cmd_t   umi_out_cmd,
   output umi_pkg::umi_addr_t  umi_out_dstaddr,
   output umi_pkg::umi_addr_t  umi_out_srcaddr,
   output umi_pkg::umi_odata_t umi_out_data,
   input  logic                umi_out_ready,
   output logic                fifo_full,
   output logic                fifo_empty
   );

   import umi_flex_pkg::*;

   split_state_t split_state;
   logic         split_busy;
   logic         more_beats;
   logic         beat_take;
   logic         fifo_push;
   logic         fifo_pop;
   umi_beat_t    cur_beat;
   umi_beat_t    fifo_head;
   umi_beat_t    out_beat;

   assign split_busy = (split_state == SPLIT_BUSY);

   umi_flex_ctrl u_ctrl
     (.umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .bypass        (bypass),
      .umi_in_valid  (umi_in_valid),
      .umi_out_ready (umi_out_ready),
      .more_beats    (more_beats),
      .fifo_full     (fifo_full),
      .fifo_empty    (fifo_empty),
      .umi_in_ready  (umi_in_ready),
      .beat_take     (beat_take),
      .fifo_push     (fifo_push),
      .fifo_pop      (fifo_pop),
      .umi_out_valid (umi_out_valid),
      .state         (split_state));

   umi_split_datapath u_datapath
     (.umi_in_clk     (umi_in_clk),
      .umi_in_nreset  (umi_in_nreset),
      .beat_take      (beat_take),
      .busy           (split_busy),
      .umi_in_cmd     (umi_in_cmd),
      .umi_in_dstaddr (umi_in_dstaddr),
      .umi_in_srcaddr (umi_in_srcaddr),
      .umi_in_data    (umi_in_data),
      .more_beats     (more_beats),
      .beat           (cur_beat));

   umi_beat_fifo #(.DEPTH(`UMI_FIFO_DEPTH)) u_fifo
     (.umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .push          (fifo_push),
      .pop           (fifo_pop),
      .din           (cur_beat),
      .dout          (fifo_head),
      .full          (fifo_full),
      .empty         (fifo_empty));

   //###################################################################
   // Output select
   //###################################################################

   assign out_beat = bypass ? cur_beat : fifo_head;  // Zero latency path

   assign umi_out_cmd     = out_beat.cmd;
   assign umi_out_dstaddr = out_beat.dstaddr;
   assign umi_out_srcaddr = out_beat.srcaddr;
   assign umi_out_data    = out_beat.data;

endmodule

/* verif/umi_fifo_flex_properties.sv */
`timescale 1ns/1ps

module umi_fifo_flex_properties
  (
   input logic                       umi_in_clk,
   input logic                       umi_in_nreset,
   input logic                       bypass,
   input logic                       umi_in_valid,
   input logic                       umi_in_ready,
   input umi_pkg::umi_cmd_t          umi_in_cmd,
   input umi_pkg::umi_addr_t         umi_in_dstaddr,
   input umi_pkg::umi_addr_t         umi_in_srcaddr,
   input umi_pkg::umi_idata_t        umi_in_data,
   input logic                       umi_out_valid,
   input logic                       umi_out_ready,
   input umi_pkg::umi_cmd_t          umi_out_cmd,
   input umi_pkg::umi_addr_t         umi_out_dstaddr,
   input umi_pkg::umi_addr_t         umi_out_srcaddr,
   input umi_pkg::umi_odata_t        umi_out_data,
   input logic                       fifo_full,
   input logic                       fifo_empty,
   input logic                       more_beats,
   input umi_flex_pkg::umi_beat_t    cur_beat,
   input umi_flex_pkg::split_state_t split_state
   );

   import umi_flex_pkg::*;

   int fail_count = 0;

   // Request held until accepted
   assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      umi_in_valid && !umi_in_ready |=> umi_in_valid && $stable(umi_in_cmd) &&
         $stable(umi_in_dstaddr) && $stable(umi_in_srcaddr) && $stable(umi_in_data))
   else
   begin
      fail_count = fail_count + 1;
      $error("Input request dropped or changed before acceptance");
   end

   // Stalled beat stays put
   assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      umi_out_valid && !umi_out_ready |=> umi_out_valid && $stable(umi_out_cmd) &&
         $stable(umi_out_dstaddr) && $stable(umi_out_srcaddr) && $stable(umi_out_data))
   else
   begin
      fail_count = fail_count + 1;
      $error("Output beat dropped or changed before transfer");
   end

   // Full FIFO stalls the splitter on its current beat
   assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      fifo_full && !bypass && (umi_in_valid || split_state == SPLIT_BUSY) |=>
         $stable(cur_beat) && $stable(split_state))
   else
   begin
      fail_count = fail_count + 1;
      $error("Beat taken while the FIFO is full");
   end

   // Multi-beat request blocks the input until its tail drains
   assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      umi_in_valid && umi_in_ready && more_beats |=>
         split_state == SPLIT_BUSY && !umi_in_ready)
   else
   begin
      fail_count = fail_count + 1;
      $error("Input ready while a remainder is pending");
   end

   // First edge out of reset
   assert property (@(posedge umi_in_clk)
      $rose(umi_in_nreset) |-> !umi_out_valid && fifo_empty && !fifo_full &&
         umi_in_ready && split_state == SPLIT_IDLE)
   else
   begin
      fail_count = fail_count + 1;
      $error("Outputs not idle after reset");
   end

endmodule

bind umi_fifo_flex umi_fifo_flex_properties u_props (.*);

/* verif/umi_fifo_flex_tb.sv */
`timescale 1ns/1ps
`include "umi_flex_defs.svh"

module umi_fifo_flex_tb;

   import umi_pkg::*;
   import umi_flex_pkg::*;

   localparam int TIMEOUT_CYCLES = 200;
   localparam int BEAT_BYTES     = 8;  // Bytes per output beat

   logic       umi_in_clk = 1'b0;
   logic       umi_in_nreset;
   logic       bypass;
   logic       umi_in_valid;
   umi_cmd_t   umi_in_cmd;
   umi_addr_t  umi_in_dstaddr;
   umi_addr_t  umi_in_srcaddr;
   umi_idata_t umi_in_data;
   logic       umi_in_ready;
   logic       umi_out_valid;
   umi_cmd_t   umi_out_cmd;
   umi_addr_t  umi_out_dstaddr;
   umi_addr_t  umi_out_srcaddr;
   umi_odata_t umi_out_data;
   logic       umi_out_ready = 1'b0;
   logic       fifo_full;
   logic       fifo_empty;

   logic       random_ready = 1'b0;  // Random output stalls
   int         full_cycles = 0;
   int         bypass_fifo_cycles = 0;  // FIFO non-empty while bypassed
   int         protocol_count = 0;
   int         mismatch_count = 0;
   int         timeout_count = 0;
   int         rx_idx = 0;
   umi_beat_t  exp_q[$];
   umi_beat_t  rx_q[$];

   umi_fifo_flex DUT (.*);

   always #10 umi_in_clk = ~umi_in_clk;

   always @(posedge umi_in_clk)
      umi_out_ready <= random_ready ? (($urandom % 3) == 0) : 1'b1;

   //######################################################################
   // Output monitor ahead of each rising edge
   //######################################################################

   always @(negedge umi_in_clk)
   begin
      umi_beat_t got;
      got.cmd     = umi_out_cmd;
      got.dstaddr = umi_out_dstaddr;
      got.srcaddr = umi_out_srcaddr;
      got.data    = umi_out_data;
      if (umi_in_nreset && umi_out_valid && umi_out_ready)
         rx_q.push_back(got);
      if (fifo_full)
         full_cycles++;
      if (bypass && !fifo_empty)
         bypass_fifo_cycles++;
      if (fifo_full && umi_in_ready)
      begin
         protocol_count++;
         $display("At %0t umi_in_ready was high while the FIFO was full", $time);
      end
   end

   task automatic check_cmd(input string what, input umi_cmd_t got, input umi_cmd_t exp);
      if (got !== exp)
      begin
         mismatch_count++;
         $display("Mismatch at %0t: %s cmd %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_beat(input string what, input umi_beat_t got, input umi_beat_t exp);
      check_cmd(what, got.cmd, exp.cmd);
      if (got.dstaddr !== exp.dstaddr || got.srcaddr !== exp.srcaddr || got.data !== exp.data)
      begin
         mismatch_count++;
         $display("Mismatch at %0t: %s dst %h src %h data %h, expected %h %h %h", $time,
                  what, got.dstaddr, got.srcaddr, got.data, exp.dstaddr, exp.srcaddr, exp.data);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         mismatch_count++;
         $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // Expected beats of one request
   task automatic expect_split(input umi_cmd_t cmd, input umi_addr_t dst, input umi_addr_t src,
                               input umi_idata_t data);
      int        wpb;
      int        left;
      int        take;
      int        idx;
      umi_beat_t b;
      wpb  = BEAT_BYTES >> cmd.size;
      left = int'(cmd.len) + 1;
      idx  = 0;
      while (left > 0)
      begin
         take        = (left > wpb) ? wpb : left;
         b.cmd       = cmd;
         b.cmd.len   = 8'(take - 1);
         b.cmd.eom   = cmd.eom & (left <= wpb);
         b.dstaddr   = dst + umi_addr_t'(BEAT_BYTES * idx);
         b.srcaddr   = src + umi_addr_t'(BEAT_BYTES * idx);
         b.data      = data[`UMI_ODW*idx +: `UMI_ODW];
         exp_q.push_back(b);
         left -= wpb;
         idx++;
      end
   endtask

   task automatic send_request(input umi_cmd_t cmd, input umi_addr_t dst, input umi_addr_t src,
                               input umi_idata_t data);
      int   waited;
      logic accepted;
      @(posedge umi_in_clk);
      umi_in_valid   <= 1'b1;
      umi_in_cmd     <= cmd;
      umi_in_dstaddr <= dst;
      umi_in_srcaddr <= src;
      umi_in_data    <= data;
      accepted = 1'b0;
      waited   = 0;
      while (!accepted && waited < TIMEOUT_CYCLES)
      begin
         @(negedge umi_in_clk);
         accepted = umi_in_ready;
         @(posedge umi_in_clk);
         waited++;
      end
      umi_in_valid <= 1'b0;
      if (!accepted)
      begin
         timeout_count++;
         $display("Timeout at %0t: request was never accepted", $time);
      end
   endtask

   task automatic issue_request(input logic [2:0] size, input logic [7:0] len);
      umi_cmd_t   cmd;
      umi_addr_t  dst;
      umi_addr_t  src;
      umi_idata_t data;
      cmd      = umi_cmd_t'($urandom);
      cmd.size = size;
      cmd.len  = len;
      cmd.eom  = 1'b1;
      dst      = {$urandom, $urandom};
      src      = {$urandom, $urandom};
      for (int i = 0; i < `UMI_IDW / 32; i++)
         data[32*i +: 32] = $urandom;
      expect_split(cmd, dst, src, data);
      send_request(cmd, dst, src, data);
   endtask

   task automatic drain_compare(input string label);
      int waited;
      waited = 0;
      while (rx_q.size() - rx_idx < exp_q.size() && waited < TIMEOUT_CYCLES)
      begin
         @(posedge umi_in_clk);
         waited++;
      end
      if (rx_q.size() - rx_idx < exp_q.size())
      begin
         timeout_count++;
         $display("Timeout in %s test: only %0d of %0d beats arrived", label,
                  rx_q.size() - rx_idx, exp_q.size());
      end
      foreach (exp_q[i])
      begin
         if (rx_idx < rx_q.size())
         begin
            check_beat($sformatf("%s beat %0d", label, i), rx_q[rx_idx], exp_q[i]);
            rx_idx++;
         end
      end
      exp_q.delete();
      repeat (8) @(posedge umi_in_clk);  // Stray beat window
      if (rx_q.size() != rx_idx)
      begin
         protocol_count++;
         $display("The %s test produced %0d more beats than expected", label,
                  rx_q.size() - rx_idx);
         rx_idx = rx_q.size();
      end
   endtask

   //######################################################################
   // Directed tests
   //######################################################################

   task automatic test_reset();
      @(negedge umi_in_clk);
      check_flag("umi_out_valid after reset", umi_out_valid, 1'b0);
      check_flag("fifo_empty after reset", fifo_empty, 1'b1);
      check_flag("umi_in_ready after reset", umi_in_ready, 1'b1);
   endtask

   task automatic test_backpressure();
      int full_before;
      full_before = full_cycles;
      random_ready <= 1'b1;
      issue_request(3'd0, 8'd31);
      issue_request(3'd1, 8'd15);
      issue_request(3'd2, 8'd3);
      issue_request(3'd3, 8'd3);
      drain_compare("backpressure");
      random_ready <= 1'b0;
      if (full_cycles == full_before)
      begin
         protocol_count++;
         $display("The FIFO never filled during the back-pressure test");
      end
   endtask

   task automatic test_bypass();
      int fifo_before;
      fifo_before = bypass_fifo_cycles;
      @(posedge umi_in_clk);
      bypass <= 1'b1;
      issue_request(3'd0, 8'd31);
      drain_compare("bypass");
      bypass <= 1'b0;
      if (bypass_fifo_cycles != fifo_before)
      begin
         protocol_count++;
         $display("The FIFO held entries while in bypass mode");
      end
   endtask

   initial
   begin
      int total;
      void'($urandom(32'h524d));
      umi_in_nreset  = 1'b0;
      bypass         = 1'b0;
      umi_in_valid   = 1'b0;
      umi_in_cmd     = '0;
      umi_in_dstaddr = '0;
      umi_in_srcaddr = '0;
      umi_in_data    = '0;
      repeat (5) @(posedge umi_in_clk);
      umi_in_nreset <= 1'b1;
      test_reset();
      issue_request(3'd3, 8'd0);  // Fits one beat
      drain_compare("short");
      issue_request(3'd0, 8'd31);
      drain_compare("long");
      test_backpressure();
      test_bypass();
      total = mismatch_count + timeout_count + protocol_count + DUT.u_props.fail_count;
      $display("Errors: %0d mismatches, %0d timeouts, %0d protocol, %0d assertions",
               mismatch_count, timeout_count, protocol_count, DUT.u_props.fail_count);
      if (total == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* tb.f */
+incdir+verilog
verilog/umi_pkg.sv
verilog/umi_flex_pkg.sv
verilog/umi_flex_ctrl.sv
verilog/umi_split_datapath.sv
verilog/umi_beat_fifo.sv
verilog/umi_fifo_flex.sv
verif/umi_fifo_flex_properties.sv
verif/umi_fifo_flex_tb.sv

/* Makefile */
# Verilator build and run for the UMI width converter

VERILATOR ?= verilator
TOP       ?= umi_fifo_flex_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
